/* logic/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

   localparam int ROB_WIDTH = 4;   // robid carries one wrap bit above this
   localparam int PRF_WIDTH = 6;

   typedef logic [2:0] funct3_t;

   // load widths
   localparam funct3_t F3_LB  = 3'b000;
   localparam funct3_t F3_LH  = 3'b001;
   localparam funct3_t F3_LW  = 3'b010;
   localparam funct3_t F3_LBU = 3'b100;
   localparam funct3_t F3_LHU = 3'b101;
   // store widths
   localparam funct3_t F3_SB  = 3'b000;
   localparam funct3_t F3_SH  = 3'b001;
   localparam funct3_t F3_SW  = 3'b010;

   typedef struct packed {
      logic [31:0]          pc;
      logic                 is_store;
      funct3_t              funct3;
      logic [31:0]          base;    // rs1
      logic [31:0]          value;   // rs2, store data
      logic [11:0]          imm;
      logic [PRF_WIDTH-1:0] prd;
      logic [ROB_WIDTH:0]   robid;
   } lsu_issue_t;

   typedef struct packed {
      logic                 valid;
      logic                 need_to_wb;   // low for stores
      logic [PRF_WIDTH-1:0] prd;
      logic [ROB_WIDTH:0]   robid;
      logic [31:0]          data;
   } lsu_wb_t;

   typedef struct packed {
      logic [31:0]        pc;
      logic [ROB_WIDTH:0] robid;
      logic [31:0]        addr;
      logic [31:0]        data;   // unshifted rs2
      funct3_t            funct3;
   } sq_entry_t;

   // true when a is younger than b, wrap bit flips the index compare
   function automatic logic rob_is_younger(input logic [ROB_WIDTH:0] a,
                                           input logic [ROB_WIDTH:0] b);
      return (a[ROB_WIDTH] ^ b[ROB_WIDTH]) ^ (a[ROB_WIDTH-1:0] > b[ROB_WIDTH-1:0]);
   endfunction

endpackage

`default_nettype wire

/* logic/lsu_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_pipe #(
   parameter int SQ_DEPTH = 4
) (
   input  wire                            clk,
   input  wire                            arst_n,
   input  wire                            issue_valid,
   input  lsu_pkg::lsu_issue_t            issue,
   input  wire                            flush_valid,
   input  wire [lsu_pkg::ROB_WIDTH:0]     flush_robid,
   output logic                           mem_issue_stall,
   input  wire [$clog2(SQ_DEPTH):0]       sq_left,
   output logic                           sq_alloc_valid,
   output lsu_pkg::sq_entry_t             sq_alloc,
   output logic [31:0]                    load_addr,
   input  wire                            fwd_hit,
   input  wire [31:0]                     fwd_data,
   input  wire                            fwd_conflict,
   output logic                           mem_read_req,
   output logic [31:0]                    mem_read_addr,
   input  wire                            mem_data_valid,
   input  wire [31:0]                     mem_data_resp,
   output lsu_pkg::lsu_wb_t               wb
);
   import lsu_pkg::*;

   logic [31:0]          agu_addr;
   logic                 reg_valid;
   lsu_issue_t           reg_op;
   logic [31:0]          reg_addr;
   logic                 need_alloc;
   logic                 load_wait;
   logic [31:0]          load_data;
   logic [31:0]          load_shifted;
   logic [31:0]          load_ext;
   logic                 wb_valid_q;
   logic                 wb_need_q;
   logic [PRF_WIDTH-1:0] wb_prd_q;
   logic [ROB_WIDTH:0]   wb_robid_q;
   logic [31:0]          wb_data_q;

   assign agu_addr = issue.base + {{20{issue.imm[11]}}, issue.imm};

   // issue pipe register
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         reg_valid <= 1'b0;
      end else if (flush_valid) begin
         if (rob_is_younger(reg_op.robid, flush_robid))
            reg_valid <= 1'b0;   // older op just holds through the flush
      end else if (!mem_issue_stall) begin
         reg_valid <= issue_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (!flush_valid && !mem_issue_stall) begin
         reg_op   <= issue;
         reg_addr <= agu_addr;
      end
   end

   // stall when the queue is full or load data is not there yet
   assign need_alloc      = reg_valid & reg_op.is_store & ~flush_valid;
   assign mem_read_req    = reg_valid & ~reg_op.is_store & ~flush_valid;
   assign mem_read_addr   = reg_addr;
   assign load_addr       = reg_addr;
   assign load_wait       = mem_read_req & (fwd_conflict | ~(fwd_hit | mem_data_valid));
   assign mem_issue_stall = (need_alloc & (sq_left == '0)) | load_wait;

   assign sq_alloc_valid  = need_alloc & ~mem_issue_stall;
   assign sq_alloc.pc     = reg_op.pc;
   assign sq_alloc.robid  = reg_op.robid;
   assign sq_alloc.addr   = reg_addr;
   assign sq_alloc.data   = reg_op.value;
   assign sq_alloc.funct3 = reg_op.funct3;

   // forwarded word wins over memory
   assign load_data    = fwd_hit ? fwd_data : mem_data_resp;
   assign load_shifted = load_data >> {reg_addr[1:0], 3'b000};

   always_comb begin
      case (reg_op.funct3)
         F3_LB:   load_ext = {{24{load_shifted[7]}}, load_shifted[7:0]};
         F3_LH:   load_ext = {{16{load_shifted[15]}}, load_shifted[15:0]};
         F3_LBU:  load_ext = {24'd0, load_shifted[7:0]};
         F3_LHU:  load_ext = {16'd0, load_shifted[15:0]};
         default: load_ext = load_data;   // LW
      endcase
   end

   // writeback register
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wb_valid_q <= 1'b0;
      end else if (flush_valid) begin
         if (rob_is_younger(wb_robid_q, flush_robid))
            wb_valid_q <= 1'b0;
      end else begin
         wb_valid_q <= reg_valid & ~mem_issue_stall;
      end
   end

   always_ff @(posedge clk) begin
      if (!flush_valid && !mem_issue_stall) begin
         wb_need_q  <= ~reg_op.is_store;
         wb_prd_q   <= reg_op.prd;
         wb_robid_q <= reg_op.robid;
         wb_data_q  <= load_ext;
      end
   end

   always_comb begin
      wb.valid      = wb_valid_q & ~flush_valid;   // held record shows after flush
      wb.need_to_wb = wb_need_q;
      wb.prd        = wb_prd_q;
      wb.robid      = wb_robid_q;
      wb.data       = wb_data_q;
   end

   // a store facing a full queue stays put in the pipe register
   a_no_alloc_when_full: assert property (
      @(posedge clk) disable iff (!arst_n)
      (need_alloc && sq_left == '0) |=> (reg_valid && $stable(reg_op))
   ) else $error("store left the pipe with no free queue entry");

   a_no_wb_on_stall: assert property (
      @(posedge clk) disable iff (!arst_n)
      (mem_read_req && mem_issue_stall) |=> !wb.valid
   ) else $error("load wrote back while stalled");

endmodule

`default_nettype wire

/* logic/store_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module store_queue #(
   parameter int SQ_DEPTH = 4
) (
   input  wire                        clk,
   input  wire                        arst_n,
   input  wire                        alloc_valid,
   input  lsu_pkg::sq_entry_t         alloc,
   output logic [$clog2(SQ_DEPTH):0]  sq_left,
   input  wire [31:0]                 load_addr,
   output logic                       fwd_hit,
   output logic [31:0]                fwd_data,
   output logic                       fwd_conflict,
   input  wire                        flush_valid,
   input  wire [lsu_pkg::ROB_WIDTH:0] flush_robid,
   input  wire                        commit_store,
   output logic                       mem_write_valid,
   output logic [31:0]                mem_write_addr,
   output logic [31:0]                mem_write_data,
   output logic [3:0]                 mem_write_be
);
   import lsu_pkg::*;

   localparam int PTR_W = $clog2(SQ_DEPTH);

   sq_entry_t        entries [SQ_DEPTH];
   logic [PTR_W:0]   head;   // extra bit tells full from empty
   logic [PTR_W:0]   tail;
   logic [PTR_W:0]   count;
   logic [PTR_W:0]   keep;   // entries surviving a flush
   logic [PTR_W-1:0] age_idx [SQ_DEPTH];
   logic             match_found;
   logic [PTR_W-1:0] match_idx;
   sq_entry_t        head_entry;
   logic             do_commit;

   assign count   = tail - head;
   assign sq_left = (PTR_W+1)'(SQ_DEPTH) - count;

   // slot of the i-th oldest entry
   always_comb begin
      for (int i = 0; i < SQ_DEPTH; i++)
         age_idx[i] = head[PTR_W-1:0] + PTR_W'(i);
   end

   // youngest entry on the same word, later slots override
   always_comb begin
      match_found = 1'b0;
      match_idx   = '0;
      for (int i = 0; i < SQ_DEPTH; i++) begin
         if (i < count && entries[age_idx[i]].addr[31:2] == load_addr[31:2]) begin
            match_found = 1'b1;
            match_idx   = age_idx[i];
         end
      end
   end

   assign fwd_hit      = match_found & (entries[match_idx].funct3 == F3_SW);
   assign fwd_conflict = match_found & (entries[match_idx].funct3 != F3_SW);
   assign fwd_data     = entries[match_idx].data;

   // entries are in age order, so the younger ones form the tail end
   always_comb begin
      keep = '0;
      for (int i = 0; i < SQ_DEPTH; i++) begin
         if (i < count && !rob_is_younger(entries[age_idx[i]].robid, flush_robid))
            keep = (PTR_W+1)'(i + 1);
      end
   end

   assign do_commit = commit_store & (count != '0);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         head <= '0;
         tail <= '0;
      end else begin
         if (do_commit)
            head <= head + 1'b1;
         if (flush_valid)
            tail <= head + keep;   // truncate back past younger stores
         else if (alloc_valid)
            tail <= tail + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (alloc_valid && !flush_valid)
         entries[tail[PTR_W-1:0]] <= alloc;
   end

   // drain head into a byte-lane write
   assign head_entry      = entries[head[PTR_W-1:0]];
   assign mem_write_valid = do_commit;
   assign mem_write_addr  = head_entry.addr;
   assign mem_write_data  = head_entry.data << {head_entry.addr[1:0], 3'b000};

   always_comb begin
      case (head_entry.funct3)
         F3_SB:   mem_write_be = 4'b0001 << head_entry.addr[1:0];
         F3_SH:   mem_write_be = 4'b0011 << head_entry.addr[1:0];
         default: mem_write_be = 4'b1111;
      endcase
   end

   a_no_commit_empty: assert property (
      @(posedge clk) disable iff (!arst_n)
      commit_store |-> (count != '0)
   ) else $error("commit with an empty store queue");

   a_no_alloc_full: assert property (
      @(posedge clk) disable iff (!arst_n)
      alloc_valid |-> (count != (PTR_W+1)'(SQ_DEPTH))
   ) else $error("allocation into a full store queue");

endmodule

`default_nettype wire

/* logic/data_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module data_mem #(
   parameter int MEM_WORDS = 256
) (
   input  wire         clk,
   input  wire         arst_n,
   input  wire         read_req,
   input  wire  [31:0] read_addr,
   output logic        data_valid,
   output logic [31:0] data_resp,
   input  wire         write_valid,
   input  wire  [31:0] write_addr,
   input  wire  [31:0] write_data,
   input  wire  [3:0]  write_be
);

   localparam int IDX_W = $clog2(MEM_WORDS);

   logic [31:0]      mem [MEM_WORDS];
   logic [IDX_W-1:0] rd_idx;
   logic [IDX_W-1:0] wr_idx;
   logic [31:0]      rd_word;
   logic             req_q;     // request seen last cycle
   logic [29:0]      addr_q;    // word it was for

   assign rd_idx = read_addr[IDX_W+1:2];
   assign wr_idx = write_addr[IDX_W+1:2];

   // same-edge write lanes go straight into the read word
   always_comb begin
      rd_word = mem[rd_idx];
      if (write_valid && wr_idx == rd_idx) begin
         for (int b = 0; b < 4; b++)
            if (write_be[b])
               rd_word[8*b +: 8] = write_data[8*b +: 8];
      end
   end

   always_ff @(posedge clk) begin
      if (write_valid) begin
         for (int b = 0; b < 4; b++)
            if (write_be[b])
               mem[wr_idx][8*b +: 8] <= write_data[8*b +: 8];
      end
      if (read_req) begin
         data_resp <= rd_word;   // reread every held cycle
         addr_q    <= read_addr[31:2];
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         req_q <= 1'b0;
      else
         req_q <= read_req;
   end

   assign data_valid = req_q & read_req & (addr_q == read_addr[31:2]);

   a_addr_in_range: assert property (
      @(posedge clk) disable iff (!arst_n)
      (read_req |-> read_addr[31:2] < MEM_WORDS) and
      (write_valid |-> write_addr[31:2] < MEM_WORDS)
   ) else $error("data memory address out of range");

endmodule

`default_nettype wire

/* logic/lsu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_top #(
   parameter int SQ_DEPTH  = 4,
   parameter int MEM_WORDS = 256
) (
   input  wire                        clk,
   input  wire                        arst_n,
   input  wire                        issue_valid,
   input  lsu_pkg::lsu_issue_t        issue,
   input  wire                        flush_valid,
   input  wire [lsu_pkg::ROB_WIDTH:0] flush_robid,
   input  wire                        commit_store,
   output logic                       mem_issue_stall,
   output lsu_pkg::lsu_wb_t           wb
);
   import lsu_pkg::*;

   logic [$clog2(SQ_DEPTH):0] sq_left;
   logic                      sq_alloc_valid;
   sq_entry_t                 sq_alloc;
   logic [31:0]               load_addr;
   logic                      fwd_hit;
   logic [31:0]               fwd_data;
   logic                      fwd_conflict;
   logic                      mem_read_req;
   logic [31:0]               mem_read_addr;
   logic                      mem_data_valid;
   logic [31:0]               mem_data_resp;
   logic                      mem_write_valid;
   logic [31:0]               mem_write_addr;
   logic [31:0]               mem_write_data;
   logic [3:0]                mem_write_be;

   lsu_pipe #(
      .SQ_DEPTH (SQ_DEPTH)
   ) u_pipe (
      .clk             (clk),
      .arst_n          (arst_n),
      .issue_valid     (issue_valid),
      .issue           (issue),
      .flush_valid     (flush_valid),
      .flush_robid     (flush_robid),
      .mem_issue_stall (mem_issue_stall),
      .sq_left         (sq_left),
      .sq_alloc_valid  (sq_alloc_valid),
      .sq_alloc        (sq_alloc),
      .load_addr       (load_addr),
      .fwd_hit         (fwd_hit),
      .fwd_data        (fwd_data),
      .fwd_conflict    (fwd_conflict),
      .mem_read_req    (mem_read_req),
      .mem_read_addr   (mem_read_addr),
      .mem_data_valid  (mem_data_valid),
      .mem_data_resp   (mem_data_resp),
      .wb              (wb)
   );

   // searched in parallel with the memory read
   store_queue #(
      .SQ_DEPTH (SQ_DEPTH)
   ) u_sq (
      .clk             (clk),
      .arst_n          (arst_n),
      .alloc_valid     (sq_alloc_valid),
      .alloc           (sq_alloc),
      .sq_left         (sq_left),
      .load_addr       (load_addr),
      .fwd_hit         (fwd_hit),
      .fwd_data        (fwd_data),
      .fwd_conflict    (fwd_conflict),
      .flush_valid     (flush_valid),
      .flush_robid     (flush_robid),
      .commit_store    (commit_store),
      .mem_write_valid (mem_write_valid),
      .mem_write_addr  (mem_write_addr),
      .mem_write_data  (mem_write_data),
      .mem_write_be    (mem_write_be)
   );

   data_mem #(
      .MEM_WORDS (MEM_WORDS)
   ) u_mem (
      .clk         (clk),
      .arst_n      (arst_n),
      .read_req    (mem_read_req),
      .read_addr   (mem_read_addr),
      .data_valid  (mem_data_valid),
      .data_resp   (mem_data_resp),
      .write_valid (mem_write_valid),
      .write_addr  (mem_write_addr),
      .write_data  (mem_write_data),
      .write_be    (mem_write_be)
   );

endmodule

`default_nettype wire

/* test/tb_lsu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_lsu;
   import lsu_pkg::*;

   localparam int SQ_DEPTH  = 4;
   localparam int MEM_WORDS = 256;
   localparam int TOTAL_OPS = 302;   // ops issued over all tests
   localparam int N_WORDS   = 16;    // words the tests touch

   typedef struct packed {
      logic [31:0]          seq;
      logic                 is_store;
      logic [PRF_WIDTH-1:0] prd;
      logic [ROB_WIDTH:0]   robid;
      logic [31:0]          data;
   } exp_rec_t;

   typedef struct packed {
      logic [31:0] seq;
      logic [31:0] addr;
      logic [31:0] value;
      funct3_t     f3;
      logic        seen;   // written back, so it sits in the queue
   } st_rec_t;

   logic                 clk;
   logic                 arst_n;
   logic                 issue_valid;
   lsu_issue_t           issue;
   logic                 flush_valid;
   logic [ROB_WIDTH:0]   flush_robid;
   logic                 commit_store;
   logic                 mem_issue_stall;
   lsu_wb_t              wb;

   logic [31:0] shadow [N_WORDS];
   exp_rec_t    exp_q[$];
   st_rec_t     pending[$];   // uncommitted stores, oldest first
   logic [31:0] rng = 32'h5e26ef17;
   logic [31:0] seq = 0;
   int          errors = 0;
   int          checks = 0;
   int          tests_run = 0;
   int          tests_failed = 0;
   int          test_errs;

   lsu_top #(.SQ_DEPTH(SQ_DEPTH), .MEM_WORDS(MEM_WORDS)) DUT (
      .clk(clk), .arst_n(arst_n), .issue_valid(issue_valid), .issue(issue),
      .flush_valid(flush_valid), .flush_robid(flush_robid), .commit_store(commit_store),
      .mem_issue_stall(mem_issue_stall), .wb(wb)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic logic [31:0] lcg();
      rng = rng * 32'd1664525 + 32'd1013904223;
      return rng;
   endfunction

   function automatic logic [31:0] apply_store(input logic [31:0] word, input st_rec_t s);
      logic [31:0] w;
      int          off;
      w   = word;
      off = s.addr[1:0];
      case (s.f3)
         F3_SB:   w[8*off +: 8]  = s.value[7:0];
         F3_SH:   w[8*off +: 16] = s.value[15:0];
         default: w = s.value;
      endcase
      return w;
   endfunction

   // reference: all older stores in order over memory, then pick and extend
   function automatic logic [31:0] expected_load(input logic [31:0] addr, input funct3_t f3);
      logic [31:0] w;
      logic [7:0]  b;
      logic [15:0] h;
      int          off;
      w = shadow[addr[5:2]];
      foreach (pending[i])
         if (pending[i].addr[5:2] == addr[5:2])
            w = apply_store(w, pending[i]);
      off = addr[1:0];
      b   = w[8*off +: 8];
      h   = (off < 3) ? w[8*off +: 16] : {8'd0, w[31:24]};
      case (f3)
         F3_LB:   return {{24{b[7]}}, b};
         F3_LBU:  return {24'd0, b};
         F3_LH:   return {{16{h[15]}}, h};
         F3_LHU:  return {16'd0, h};
         default: return w;
      endcase
   endfunction

   function automatic void commit_model();
      st_rec_t s;
      s = pending.pop_front();
      shadow[s.addr[5:2]] = apply_store(shadow[s.addr[5:2]], s);
   endfunction

   // issue one op, committing the oldest store while stalled
   task automatic do_op(input logic is_store, input funct3_t f3, input logic [31:0] addr,
                        input logic [31:0] value);
      lsu_issue_t op;
      exp_rec_t   e;
      st_rec_t    s;
      logic [31:0] r;
      logic       taken;
      logic       commit_next;
      r           = lcg();
      op.pc       = {seq[29:0], 2'b00};
      op.is_store = is_store;
      op.funct3   = f3;
      op.imm      = {{5{r[6]}}, r[6:0]};
      op.base     = addr - {{20{op.imm[11]}}, op.imm};
      op.value    = value;
      op.prd      = r[12:7];
      op.robid    = seq[ROB_WIDTH:0];
      @(posedge clk);
      issue_valid <= 1'b1;
      issue       <= op;
      taken = 1'b0;
      while (!taken) begin
         @(negedge clk);
         taken       = !mem_issue_stall;
         commit_next = 1'b0;
         if (!taken && pending.size() > 0 && pending[0].seen)
            commit_next = 1'b1;
         @(posedge clk);
         commit_store <= commit_next;
         if (commit_next)
            commit_model();
      end
      issue_valid <= 1'b0;
      e.seq      = seq;
      e.is_store = is_store;
      e.prd      = op.prd;
      e.robid    = op.robid;
      e.data     = is_store ? 32'd0 : expected_load(addr, f3);
      exp_q.push_back(e);
      if (is_store) begin
         s.seq   = seq;
         s.addr  = addr;
         s.value = value;
         s.f3    = f3;
         s.seen  = 1'b0;
         pending.push_back(s);
      end
      seq = seq + 1;
   endtask

   task automatic commit_one();
      if (pending.size() > 0 && pending[0].seen) begin
         @(posedge clk);
         commit_store <= 1'b1;
         commit_model();
         @(posedge clk);
         commit_store <= 1'b0;
      end
   endtask

   task automatic flush_at(input logic [31:0] fseq);
      exp_rec_t ek[$];
      st_rec_t  sk[$];
      @(posedge clk);
      flush_valid <= 1'b1;
      flush_robid <= fseq[ROB_WIDTH:0];
      foreach (exp_q[i])
         if (exp_q[i].seq <= fseq)
            ek.push_back(exp_q[i]);
      foreach (pending[i])
         if (pending[i].seq <= fseq)
            sk.push_back(pending[i]);
      exp_q   = ek;
      pending = sk;
      @(posedge clk);
      flush_valid <= 1'b0;
   endtask

   task automatic wait_writebacks();
      while (exp_q.size() > 0)
         @(negedge clk);
   endtask

   // commit everything and wait for all writebacks
   task automatic drain();
      logic commit_next;
      while (exp_q.size() > 0 || pending.size() > 0) begin
         @(negedge clk);
         commit_next = pending.size() > 0 && pending[0].seen;
         @(posedge clk);
         commit_store <= commit_next;
         if (commit_next)
            commit_model();
      end
      @(posedge clk);
      commit_store <= 1'b0;
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (errors != test_errs)
         tests_failed++;
      $display("test %0d %s: %s", tests_run, name, (errors == test_errs) ? "ok" : "errors");
      test_errs = errors;
   endtask

   // compare each writeback against the oldest expected record
   initial begin : compare
      exp_rec_t e;
      st_rec_t  s;
      forever begin
         @(negedge clk);
         if (arst_n && wb.valid) begin
            assert (exp_q.size() != 0) else begin
               $display("%0t: writeback seen with no operation outstanding", $time);
               errors++;
            end
            if (exp_q.size() != 0) begin
               e = exp_q.pop_front();
               checks++;
               assert (wb.robid == e.robid) else begin
                  $display("Mismatch at %0t: wb.robid = %h, expected %h", $time, wb.robid, e.robid);
                  errors++;
               end
               assert (wb.prd == e.prd) else begin
                  $display("Mismatch at %0t: wb.prd = %h, expected %h", $time, wb.prd, e.prd);
                  errors++;
               end
               assert (wb.need_to_wb == !e.is_store) else begin
                  $display("Mismatch at %0t: wb.need_to_wb = %b, expected %b", $time,
                           wb.need_to_wb, !e.is_store);
                  errors++;
               end
               if (!e.is_store) begin
                  assert (wb.data == e.data) else begin
                     $display("Mismatch at %0t: wb.data = %h, expected %h", $time, wb.data, e.data);
                     errors++;
                  end
               end else begin
                  foreach (pending[i])
                     if (pending[i].seq == e.seq) begin
                        s = pending[i];
                        s.seen = 1'b1;
                        pending[i] = s;
                     end
               end
            end
         end
      end
   end

   initial begin : watchdog
      repeat (TOTAL_OPS * 20 + 16) @(posedge clk);
      $display("timeout: the tests did not finish in the expected time");
      $display("SIMULATION FAILED");
      $finish;
   end

   initial begin : main
      logic [31:0] r;
      logic [31:0] a;
      funct3_t     f;
      logic [31:0] first_ld;
      arst_n       = 1'b0;
      issue_valid  = 1'b0;
      issue        = '0;
      flush_valid  = 1'b0;
      flush_robid  = '0;
      commit_store = 1'b0;
      test_errs    = 0;
      repeat (16) @(posedge clk);
      arst_n <= 1'b1;

      // fill pattern over the whole word address
      for (int w = 0; w < N_WORDS; w++)
         do_op(1'b1, F3_SW, 32'(w * 4), 32'h9e3779b9 * 32'(w + 1) ^ 32'(w << 20));
      do_op(1'b1, F3_SW, 32'd24, 32'h80ff7f01);
      drain();
      end_test("memory fill");

      for (int w = 5; w < 7; w++) begin
         for (int o = 0; o < 4; o++) begin
            do_op(1'b0, F3_LB, 32'(w * 4 + o), 0);
            do_op(1'b0, F3_LBU, 32'(w * 4 + o), 0);
         end
         for (int o = 0; o < 4; o += 2) begin
            do_op(1'b0, F3_LH, 32'(w * 4 + o), 0);
            do_op(1'b0, F3_LHU, 32'(w * 4 + o), 0);
         end
         do_op(1'b0, F3_LW, 32'(w * 4), 0);
      end
      drain();
      end_test("load widths and extension");

      do_op(1'b1, F3_SW, 32'd32, 32'hcafe1234);
      do_op(1'b0, F3_LW, 32'd32, 0);
      wait_writebacks();   // no commit yet, so the word must come from the queue
      drain();
      end_test("sw forwarding");

      do_op(1'b1, F3_SB, 32'd37, 32'h000000a5);
      do_op(1'b0, F3_LW, 32'd36, 0);
      repeat (6) @(posedge clk);
      assert (exp_q.size() == 1 && exp_q[0].is_store == 1'b0) else begin
         $display("%0t: load behind a byte store wrote back before the commit", $time);
         errors++;
      end
      drain();
      end_test("sb conflict wait");

      // last store lands on the first one's word, so order shows in memory
      for (int i = 0; i <= SQ_DEPTH; i++)
         do_op(1'b1, F3_SW, 32'(40 + 4 * (i % SQ_DEPTH)), 32'h11110000 + 32'(i));
      repeat (4) @(negedge clk);
      assert (mem_issue_stall) else begin
         $display("%0t: full store queue did not raise mem_issue_stall", $time);
         errors++;
      end
      assert (exp_q.size() == 1) else begin
         $display("%0t: store writebacks out of step with the full store queue", $time);
         errors++;
      end
      drain();
      for (int i = 0; i <= SQ_DEPTH; i++)
         do_op(1'b0, F3_LW, 32'(40 + 4 * i), 0);
      drain();
      end_test("store queue full");

      do_op(1'b1, F3_SW, 32'd12, 32'h0badf00d);
      first_ld = seq;
      do_op(1'b0, F3_LW, 32'd12, 0);
      do_op(1'b1, F3_SW, 32'd16, 32'hdeadbeef);
      do_op(1'b0, F3_LW, 32'd16, 0);
      flush_at(first_ld);
      drain();
      do_op(1'b0, F3_LW, 32'd16, 0);   // flushed store must not show here
      drain();
      end_test("flush");

      for (int i = 0; i < 240; i++) begin
         r = lcg();
         a = {26'd0, r[11:8], 2'b00};
         if (r[2:0] < 3'd3) begin
            f = (r[4:3] == 2'd0) ? F3_SB : (r[4:3] == 2'd1) ? F3_SH : F3_SW;
            if (f == F3_SB) a[1:0] = r[13:12];
            if (f == F3_SH) a[1]   = r[13];
            do_op(1'b1, f, a, lcg());
         end else begin
            case (r[14:12] % 5)
               0: f = F3_LB;
               1: f = F3_LBU;
               2: f = F3_LH;
               3: f = F3_LHU;
               default: f = F3_LW;
            endcase
            if (f == F3_LB || f == F3_LBU) a[1:0] = r[16:15];
            if (f == F3_LH || f == F3_LHU) a[1]   = r[15];
            do_op(1'b0, f, a, 0);
         end
         // keep in-flight ops well inside the ROB window
         if (r[19:18] != 2'd0 || (pending.size() > 0 && seq - pending[0].seq > 8))
            commit_one();
         if (r[23:20] == 4'd0)
            flush_at(seq - 1 - 32'(r[25:24] % 3));
      end
      drain();
      end_test("random mix");

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* compile.f */
logic/lsu_pkg.sv
logic/lsu_pipe.sv
logic/store_queue.sv
logic/data_mem.sv
logic/lsu_top.sv
test/tb_lsu.sv

/* Bender.yml */
package:
  name: lsu

sources:
  - logic/lsu_pkg.sv
  - logic/lsu_pipe.sv
  - logic/store_queue.sv
  - logic/data_mem.sv
  - logic/lsu_top.sv
  - target: test
    files:
      - test/tb_lsu.sv
